// File: vga_golden.txt
// columns kind_frame_sel_addr_x_data, kind 1 is a host write issued right after reset (frame 1)
// or after the vsync of frame 2, kind 2 is an expected pixel with addr as line y and rgb in data
1_1_1_000_000_0123
1_1_1_001_000_0f00
1_1_1_002_000_00f0
1_1_1_003_000_000f
1_1_0_000_000_2141
1_1_0_007_000_0342
1_1_0_008_000_3143
1_1_0_00f_000_1244
1_1_2_410_000_0018
1_1_2_415_000_007e
1_1_2_420_000_0081
1_1_2_430_000_00f0
1_1_2_44f_000_000f
1_2_1_001_000_0ff0
2_2_0_000_000_00f0
2_2_0_000_003_0f00
2_2_0_000_004_0f00
2_2_0_000_007_00f0
2_2_0_000_038_000f
2_2_0_000_039_0123
2_2_0_000_03f_000f
2_2_0_005_000_00f0
2_2_0_005_001_0f00
2_2_0_010_000_0f00
2_2_0_010_004_000f
2_2_0_01f_038_0f00
2_2_0_01f_03c_00f0
2_3_0_000_003_0ff0
2_3_0_010_000_0ff0
2_3_0_01f_038_0ff0
2_3_0_000_038_000f

// File: list.f
vga_pkg.sv
vga_timing.sv
char_store.sv
glyph_renderer.sv
pixel_out.sv
vga_text_top.sv
tb_vga_text.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the VGA text testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_vga_text -o sim_vga_text

# the simulation stops with a failing status on error, so the search decides
sim_out=$(./obj_dir/sim_vga_text 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

// File: tb_vga_text.sv
// testbench for the 64x32 timing that reads vga_golden.txt from the directory the run starts in
`timescale 1ns/1ns

module tb_vga_text import vga_pkg::*; ();

  //////////////////////////////////////////////////////////////////////
  // small test timing
  //////////////////////////////////////////////////////////////////////

  localparam int H_VISIBLE = 64;
  localparam int H_FRONT   = 4;
  localparam int H_SYNC    = 8;
  localparam int H_BACK    = 12;
  localparam int V_VISIBLE = 32;
  localparam int V_FRONT   = 2;
  localparam int V_SYNC    = 2;
  localparam int V_BACK    = 4;

  localparam int H_TOTAL      = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  // pixel 0 trails the hsync rise, line 0 trails the vsync rise
  localparam int PIXEL_OFFSET = H_SYNC + H_BACK;
  localparam int LINE_OFFSET  = V_SYNC + V_BACK;
  localparam int RESET_CYCLES = 5;
  localparam int GOLDEN_DEPTH = 64;
  localparam string GOLDEN_FILE = "vga_golden.txt";
  localparam rgb_t BLACK = '0;

  logic       clk = 1'b0;
  logic       nrst;
  host_wr_t   host;
  logic       hsync;
  logic       vsync;
  logic [3:0] red;
  logic [3:0] green;
  logic [3:0] blue;

  // golden entries: kind, frame, sel, addr or y, x, data or rgb
  logic [51:0] golden [GOLDEN_DEPTH];
  logic [51:0] boot_writes [$];
  logic [51:0] late_writes [$];
  int          chk_frame [$];
  int          chk_y [$];
  int          chk_x [$];
  rgb_t        chk_rgb [$];
  bit          chk_hit [$];

  // beam tracking from the pins
  int cycles      = 0;
  int cycle_limit = 4 * FRAME_CYCLES;
  int since_hs    = 0;
  int since_vs    = 0;
  int line_rises  = 0;
  int vs_count    = 0;
  bit h_known     = 1'b0;
  bit v_known     = 1'b0;
  bit hsync_prev  = 1'b0;
  bit vsync_prev  = 1'b0;

  always #50 clk = ~clk;

  vga_text_top #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) uut (
    .clk(clk), .nrst(nrst), .host(host),
    .hsync(hsync), .vsync(vsync), .red(red), .green(green), .blue(blue)
  );

  //////////////////////////////////////////////////////////////////////
  // reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string text);
    $display("%s", text);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_pixel(input rgb_t seen, input rgb_t expected, input int y, input int x);
    if (seen !== expected)
      abort_run($sformatf("[FAIL] %0t ns: pixel x=%0d y=%0d shows %h, expected %h",
                          $time, x, y, seen, expected));
  endtask

  task automatic check_count(input coord_t seen, input coord_t expected, input string what);
    if (seen !== expected)
      abort_run($sformatf("[FAIL] %0t ns: %s is %0d cycles, expected %0d",
                          $time, what, seen, expected));
  endtask

  //////////////////////////////////////////////////////////////////////
  // golden file
  //////////////////////////////////////////////////////////////////////

  task automatic load_golden();
    int          fd;
    int          kind;
    logic [51:0] entry;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0)
      abort_run("the golden file vga_golden.txt is missing or cannot be read");
    $fclose(fd);
    for (int i = 0; i < GOLDEN_DEPTH; i++)
      golden[i] = '0;
    $readmemh(GOLDEN_FILE, golden);
    for (int i = 0; i < GOLDEN_DEPTH; i++)
    begin
      entry = golden[i];
      kind  = int'(entry[51:48]);
      // an all zero word ends the list
      if (kind == 0)
        break;
      if (kind == 1)
      begin
        // frame 1 writes follow reset, later ones follow that frame's vsync
        if (int'(entry[47:44]) == 1)
          boot_writes.push_back(entry);
        else
          late_writes.push_back(entry);
      end
      else if (kind == 2)
      begin
        chk_frame.push_back(int'(entry[47:44]));
        chk_y.push_back(int'(entry[39:28]));
        chk_x.push_back(int'(entry[27:16]));
        chk_rgb.push_back(rgb_t'(entry[11:0]));
        chk_hit.push_back(1'b0);
      end
      else
        abort_run($sformatf("the golden file has an unknown entry kind at entry %0d", i));
    end
    if (chk_y.size() == 0)
      abort_run("the golden file holds no expected pixels");
    // three frames plus reset and the writes, with two lines of slack
    cycle_limit = 3 * FRAME_CYCLES + RESET_CYCLES + boot_writes.size()
                  + late_writes.size() + 2 * H_TOTAL;
  endtask

  // one host write, 10 ns after the edge
  task automatic apply_write(input logic [51:0] entry);
    @(posedge clk);
    #10;
    host.strobe = 1'b1;
    host.sel    = mem_sel_t'(entry[41:40]);
    host.addr   = entry[39:28];
    host.data   = entry[15:0];
  endtask

  task automatic release_host();
    @(posedge clk);
    #10;
    host = '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // pin monitor, sampled on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    rgb_t seen;
    int   x;
    int   y;
    bit   outside;
    seen = rgb_t'({red, green, blue});
    cycles++;
    if (cycles > cycle_limit)
      abort_run($sformatf("timeout: the run did not finish within %0d cycles", cycle_limit));
    if (nrst)
    begin
      since_hs++;
      since_vs++;
      // frame start, period checked from the second rise on
      if (vsync && !vsync_prev)
      begin
        if (v_known)
          check_count(coord_t'(since_vs), coord_t'(FRAME_CYCLES), "vsync period");
        since_vs   = 0;
        line_rises = 0;
        v_known    = 1'b1;
        vs_count++;
      end
      // each hsync rise opens the next line
      if (hsync && !hsync_prev)
      begin
        if (h_known)
          check_count(coord_t'(since_hs), coord_t'(H_TOTAL), "hsync period");
        since_hs = 0;
        h_known  = 1'b1;
        line_rises++;
      end
      x = since_hs - PIXEL_OFFSET;
      y = line_rises - LINE_OFFSET;
      outside = (h_known && (x < 0 || x >= H_VISIBLE))
                || (v_known && (y < 0 || y >= V_VISIBLE));
      if (outside)
        check_pixel(seen, BLACK, y, x);
      else if (h_known && v_known)
      begin
        // frame 2 starts after the first vsync seen
        foreach (chk_y[i])
        begin
          if (chk_frame[i] == vs_count + 1 && chk_y[i] == y && chk_x[i] == x)
          begin
            check_pixel(seen, chk_rgb[i], y, x);
            chk_hit[i] = 1'b1;
          end
        end
      end
    end
    hsync_prev = hsync;
    vsync_prev = vsync;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int missed;
    nrst   = 1'b0;
    host   = '0;
    missed = 0;
    load_golden();
    repeat (RESET_CYCLES) @(posedge clk);
    #10;
    nrst = 1'b1;
    foreach (boot_writes[i])
      apply_write(boot_writes[i]);
    release_host();
    // palette rewrite once frame 2 has shown its last visible line
    wait (vs_count >= 2);
    foreach (late_writes[i])
      apply_write(late_writes[i]);
    release_host();
    wait (vs_count >= 3);
    foreach (chk_hit[i])
    begin
      if (!chk_hit[i])
        missed++;
    end
    if (missed == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      abort_run($sformatf("%0d expected pixels from the golden file were never shown", missed));
    end
  end

endmodule

// File: vga_text_top.sv
// vga text display top level where H_VISIBLE+4 must be below the line total and all totals below 4096
`timescale 1ns/1ns

module vga_text_top import vga_pkg::*; #(
  parameter int H_VISIBLE = 800,
  parameter int H_FRONT   = 40,
  parameter int H_SYNC    = 128,
  parameter int H_BACK    = 88,
  parameter int V_VISIBLE = 600,
  parameter int V_FRONT   = 1,
  parameter int V_SYNC    = 4,
  parameter int V_BACK    = 23
) (
  input  logic       clk,
  input  logic       nrst,
  input  host_wr_t   host,
  output logic       hsync,
  output logic       vsync,
  output logic [3:0] red,
  output logic [3:0] green,
  output logic [3:0] blue
);

  localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  // a partial last row or column still gets a cell
  localparam int TEXT_COLS = (H_VISIBLE + GLYPH_W - 1) / GLYPH_W;
  localparam int TEXT_ROWS = (V_VISIBLE + GLYPH_H - 1) / GLYPH_H;

  scan_pos_t   pos;
  logic        tim_hsync;
  logic        tim_vsync;
  logic [11:0] text_addr;
  logic [11:0] font_addr;
  logic [3:0]  pal_addr;
  cell_t       text_cell;
  rgb_t        pal_color;
  logic [7:0]  font_bits;
  logic        wr;
  coord_t      wr_x;
  rgb_t        wr_pixel;

  //////////////////////////////////////////////////////////////////////
  // timing, storage, rendering, output
  //////////////////////////////////////////////////////////////////////

  vga_timing #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) u_timing (
    .clk(clk), .nrst(nrst), .pos(pos), .hsync(tim_hsync), .vsync(tim_vsync)
  );

  char_store #(.TEXT_COLS(TEXT_COLS), .TEXT_ROWS(TEXT_ROWS)) u_store (
    .clk(clk), .host(host),
    .text_addr(text_addr), .font_addr(font_addr), .pal_addr(pal_addr),
    .text_cell(text_cell), .pal_color(pal_color), .font_bits(font_bits)
  );

  glyph_renderer #(
    .H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE), .V_TOTAL(V_TOTAL), .TEXT_COLS(TEXT_COLS)
  ) u_render (
    .clk(clk), .nrst(nrst), .pos(pos),
    .text_addr(text_addr), .font_addr(font_addr), .pal_addr(pal_addr),
    .text_cell(text_cell), .pal_color(pal_color), .font_bits(font_bits),
    .wr(wr), .wr_x(wr_x), .wr_pixel(wr_pixel)
  );

  pixel_out #(.H_VISIBLE(H_VISIBLE)) u_out (
    .clk(clk), .nrst(nrst), .pos(pos), .hsync_in(tim_hsync), .vsync_in(tim_vsync),
    .wr(wr), .wr_x(wr_x), .wr_pixel(wr_pixel),
    .hsync(hsync), .vsync(vsync), .red(red), .green(green), .blue(blue)
  );

endmodule

// File: pixel_out.sv
// ping-pong line buffer output stage where bank parity assumes an even number of lines per frame
`timescale 1ns/1ns

module pixel_out import vga_pkg::*; #(
  parameter int H_VISIBLE = 800
) (
  input  logic      clk,
  input  logic      nrst,
  input  scan_pos_t pos,
  input  logic      hsync_in,
  input  logic      vsync_in,
  input  logic      wr,
  input  coord_t    wr_x,
  input  rgb_t      wr_pixel,
  output logic      hsync,
  output logic      vsync,
  output logic [3:0] red,
  output logic [3:0] green,
  output logic [3:0] blue
);

  localparam int     LB_AW = $clog2(H_VISIBLE);
  localparam coord_t H_VIS = coord_t'(H_VISIBLE);

  //////////////////////////////////////////////////////////////////////
  // line buffer
  //////////////////////////////////////////////////////////////////////

  // bank of line y is vcount parity
  rgb_t lbuf [2][H_VISIBLE];

  logic rd_bank;
  logic wr_bank;
  rgb_t rd_pixel;

  // renderer fills the bank of the next line
  assign rd_bank = pos.vcount[0];
  assign wr_bank = ~pos.vcount[0];

  always_ff @(posedge clk)
  begin
    if (wr)
      lbuf[wr_bank][wr_x[LB_AW-1:0]] <= wr_pixel;
  end

  // first output stage, read at hcount
  always_ff @(posedge clk)
  begin
    if (pos.hcount < H_VIS)
      rd_pixel <= lbuf[rd_bank][pos.hcount[LB_AW-1:0]];
  end

  //////////////////////////////////////////////////////////////////////
  // blanking and sync alignment
  //////////////////////////////////////////////////////////////////////

  logic               vis_d;
  logic [OUT_LAG-1:0] hs_pipe;
  logic [OUT_LAG-1:0] vs_pipe;
  rgb_t               color;

  // second stage, colour forced to zero outside the window
  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      vis_d   <= 1'b0;
      hs_pipe <= '0;
      vs_pipe <= '0;
      color   <= '0;
    end
    else
    begin
      vis_d   <= pos.visible;
      // syncs ride alongside the colour
      hs_pipe <= {hs_pipe[OUT_LAG-2:0], hsync_in};
      vs_pipe <= {vs_pipe[OUT_LAG-2:0], vsync_in};
      color   <= vis_d ? rd_pixel : '0;
    end
  end

  assign hsync = hs_pipe[OUT_LAG-1];
  assign vsync = vs_pipe[OUT_LAG-1];
  assign red   = color.red;
  assign green = color.green;
  assign blue  = color.blue;

endmodule

// File: glyph_renderer.sv
// renders the next visible line from hcount 0 and finishes H_VISIBLE+4 cycles later so the line must be longer
`timescale 1ns/1ns

module glyph_renderer import vga_pkg::*; #(
  parameter int H_VISIBLE = 800,
  parameter int V_VISIBLE = 600,
  parameter int V_TOTAL   = 628,
  parameter int TEXT_COLS = 100
) (
  input  logic        clk,
  input  logic        nrst,
  input  scan_pos_t   pos,
  output logic [11:0] text_addr,
  output logic [11:0] font_addr,
  output logic [3:0]  pal_addr,
  input  cell_t       text_cell,
  input  rgb_t        pal_color,
  input  logic [7:0]  font_bits,
  output logic        wr,
  output coord_t      wr_x,
  output rgb_t        wr_pixel
);

  typedef enum logic [1:0] {
    IDLE,
    PRIME,
    DRAW
  } render_state_t;

  localparam coord_t      LAST_LINE = coord_t'(V_TOTAL - 1);
  localparam coord_t      VIS_LINES = coord_t'(V_VISIBLE);
  localparam coord_t      LAST_X    = coord_t'(H_VISIBLE - 1);
  localparam logic [11:0] COLS      = 12'(TEXT_COLS);
  localparam logic [11:0] LAST_COL  = 12'(TEXT_COLS - 1);

  render_state_t state;
  logic [2:0]    tick;
  logic [11:0]   col;
  logic [11:0]   col_step;
  coord_t        render_line;
  logic [11:0]   text_row;
  logic          start;
  logic          busy;

  // cell being fetched
  logic [3:0]    fg_attr;
  logic [7:0]    next_pattern;
  rgb_t          next_bg;

  // cell being shifted out
  logic [7:0]    cur_pattern;
  rgb_t          cur_bg;
  rgb_t          cur_fg;

  //////////////////////////////////////////////////////////////////////
  // line and address generation
  //////////////////////////////////////////////////////////////////////

  // the last frame line renders visible line 0
  // vcount holds still for the whole render
  always_comb
  begin
    if (pos.vcount == LAST_LINE)
      render_line = '0;
    else
      render_line = pos.vcount + 12'd1;
    text_row = 12'(render_line / GLYPH_H);
    start    = (state == IDLE) && (pos.hcount == '0) && (render_line < VIS_LINES);
    busy     = (state != IDLE);
    // stays on the last column for the fetch past the line end
    col_step = (col == LAST_COL) ? col : col + 12'd1;
  end

  // tick 0 reads the cell
  assign text_addr = text_row * COLS + col;
  // tick 1 addresses the glyph row of the code just read
  assign font_addr = {text_cell.code, 4'(render_line % GLYPH_H)};
  // background on tick 1, foreground on tick 2
  assign pal_addr  = (tick == 3'd2) ? fg_attr : text_cell.bg;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      state <= IDLE;
      tick  <= '0;
      col   <= '0;
      wr    <= 1'b0;
      wr_x  <= '0;
    end
    else
    begin
      // start cycle counts as tick 0
      if (!busy)
        tick <= start ? 3'd1 : 3'd0;
      else
        tick <= tick + 3'd1;

      // column moves on after each text read
      if (!busy && !start)
        col <= '0;
      else if (start || tick == 3'd0)
        col <= col_step;

      case (state)
        IDLE:
        begin
          if (start)
            state <= PRIME;
        end
        // first cell completes on tick 3, first write lands 4 cycles after start
        PRIME:
        begin
          if (tick == 3'd3)
          begin
            state <= DRAW;
            wr    <= 1'b1;
            wr_x  <= '0;
          end
        end
        // one pixel per cycle until the line is full
        DRAW:
        begin
          if (wr_x == LAST_X)
          begin
            state <= IDLE;
            wr    <= 1'b0;
          end
          else
          begin
            wr_x <= wr_x + 12'd1;
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // fetch and shift datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (busy)
    begin
      // hold fg attribute until the palette is free
      if (tick == 3'd1)
        fg_attr <= text_cell.fg;
      // pattern and background colour arrive together
      if (tick == 3'd2)
      begin
        next_pattern <= font_bits;
        next_bg      <= pal_color;
      end
      // foreground colour arrives and the cell takes over the shifter
      // its first pixel goes out straight away, msb first
      if (tick == 3'd3)
      begin
        cur_pattern <= {next_pattern[6:0], 1'b0};
        cur_bg      <= next_bg;
        cur_fg      <= pal_color;
        wr_pixel    <= next_pattern[7] ? pal_color : next_bg;
      end
      else
      begin
        cur_pattern <= cur_pattern << 1;
        wr_pixel    <= cur_pattern[7] ? cur_fg : cur_bg;
      end
    end
  end

endmodule

// File: char_store.sv
// host loaded text, palette and font memories with no reset so their content is undefined until written
`timescale 1ns/1ns

module char_store import vga_pkg::*; #(
  parameter int TEXT_COLS = 100,
  parameter int TEXT_ROWS = 38
) (
  input  logic        clk,
  input  host_wr_t    host,
  input  logic [11:0] text_addr,
  input  logic [11:0] font_addr,
  input  logic [3:0]  pal_addr,
  output cell_t       text_cell,
  output rgb_t        pal_color,
  output logic [7:0]  font_bits
);

  localparam int TEXT_DEPTH = TEXT_COLS * TEXT_ROWS;
  localparam int TEXT_AW    = $clog2(TEXT_DEPTH);
  // one bit wider so a full 4096 entry buffer still compares
  localparam logic [12:0] TEXT_LIMIT = 13'(TEXT_DEPTH);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // row major, addr = row * TEXT_COLS + col
  cell_t      text_mem [TEXT_DEPTH];
  rgb_t       pal_mem  [PALETTE_SIZE];
  // addr = code * 16 + glyph row
  logic [7:0] font_mem [FONT_DEPTH];

  logic text_we;
  logic pal_we;
  logic font_we;

  // route the strobe by target memory
  always_comb
  begin
    text_we = 1'b0;
    pal_we  = 1'b0;
    font_we = 1'b0;
    case (host.sel)
      SEL_TEXT:    text_we = host.strobe && ({1'b0, host.addr} < TEXT_LIMIT);
      SEL_PALETTE: pal_we  = host.strobe;
      SEL_FONT:    font_we = host.strobe;
      default:     ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // host writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (text_we)
      text_mem[host.addr[TEXT_AW-1:0]] <= cell_t'(host.data);
    // palette colour sits in the low 12 data bits
    if (pal_we)
      pal_mem[host.addr[3:0]] <= rgb_t'(host.data[11:0]);
    // glyph pattern sits in the low byte
    if (font_we)
      font_mem[host.addr] <= host.data[7:0];
  end

  //////////////////////////////////////////////////////////////////////
  // renderer read ports
  //////////////////////////////////////////////////////////////////////

  // every port returns its word one cycle after the address
  always_ff @(posedge clk)
  begin
    text_cell <= text_mem[text_addr[TEXT_AW-1:0]];
    pal_color <= pal_mem[pal_addr];
    font_bits <= font_mem[font_addr];
  end

endmodule

// File: vga_timing.sv
// registered scan counters with active high syncs where pixel 0 comes H_SYNC+H_BACK cycles after hsync rises
`timescale 1ns/1ns

module vga_timing import vga_pkg::*; #(
  parameter int H_VISIBLE = 800,
  parameter int H_FRONT   = 40,
  parameter int H_SYNC    = 128,
  parameter int H_BACK    = 88,
  parameter int V_VISIBLE = 600,
  parameter int V_FRONT   = 1,
  parameter int V_SYNC    = 4,
  parameter int V_BACK    = 23
) (
  input  logic      clk,
  input  logic      nrst,
  output scan_pos_t pos,
  output logic      hsync,
  output logic      vsync
);

  //////////////////////////////////////////////////////////////////////
  // interval boundaries
  //////////////////////////////////////////////////////////////////////

  // line runs visible, front porch, sync, back porch
  localparam coord_t H_VIS      = coord_t'(H_VISIBLE);
  localparam coord_t H_SYNC_BEG = coord_t'(H_VISIBLE + H_FRONT);
  localparam coord_t H_SYNC_END = coord_t'(H_VISIBLE + H_FRONT + H_SYNC);
  localparam coord_t H_LAST     = coord_t'(H_VISIBLE + H_FRONT + H_SYNC + H_BACK - 1);

  // frame runs the same way in lines
  localparam coord_t V_VIS      = coord_t'(V_VISIBLE);
  localparam coord_t V_SYNC_BEG = coord_t'(V_VISIBLE + V_FRONT);
  localparam coord_t V_SYNC_END = coord_t'(V_VISIBLE + V_FRONT + V_SYNC);
  localparam coord_t V_LAST     = coord_t'(V_VISIBLE + V_FRONT + V_SYNC + V_BACK - 1);

  coord_t h_next;
  coord_t v_next;

  // next beam position
  always_comb
  begin
    h_next = pos.hcount + 12'd1;
    v_next = pos.vcount;
    if (pos.hcount == H_LAST)
    begin
      h_next = '0;
      // vcount steps on the horizontal wrap
      if (pos.vcount == V_LAST)
        v_next = '0;
      else
        v_next = pos.vcount + 12'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // registered position, visible flag and syncs
  //////////////////////////////////////////////////////////////////////

  // flags come from the next position so they match the counters
  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      pos.hcount  <= '0;
      pos.vcount  <= '0;
      // (0,0) lies inside the visible window
      pos.visible <= 1'b1;
      hsync       <= 1'b0;
      vsync       <= 1'b0;
    end
    else
    begin
      pos.hcount  <= h_next;
      pos.vcount  <= v_next;
      pos.visible <= (h_next < H_VIS) && (v_next < V_VIS);
      hsync       <= (h_next >= H_SYNC_BEG) && (h_next < H_SYNC_END);
      vsync       <= (v_next >= V_SYNC_BEG) && (v_next < V_SYNC_END);
    end
  end

endmodule

// File: vga_pkg.sv
// shared types and fixed format constants for the text display with beam coordinates held in 12 bits
package vga_pkg;

  //////////////////////////////////////////////////////////////////////
  // format constants
  //////////////////////////////////////////////////////////////////////

  // one text cell is 8 pixels wide and 16 rows high
  localparam int GLYPH_W = 8;
  localparam int GLYPH_H = 16;

  // attribute values index a 16 entry palette
  localparam int PALETTE_SIZE = 16;

  // 256 glyphs of 16 rows each
  localparam int FONT_DEPTH = 4096;

  // cycles from a beam position to its colour on the pins
  localparam int OUT_LAG = 2;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  // 12 bit colour as used by the palette, line buffer and pins
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  // one text cell, background attribute in the top nibble
  typedef struct packed {
    logic [3:0] bg;
    logic [3:0] fg;
    logic [7:0] code;
  } cell_t;

  // beam coordinate for both axes
  typedef logic [11:0] coord_t;

  // pixel the timing generator points at this cycle
  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   visible;
  } scan_pos_t;

  // target memory of a host write
  typedef enum logic [1:0] {
    SEL_TEXT,
    SEL_PALETTE,
    SEL_FONT
  } mem_sel_t;

  // host write strobe with its address and data
  typedef struct packed {
    logic        strobe;
    mem_sel_t    sel;
    logic [11:0] addr;
    logic [15:0] data;
  } host_wr_t;

endpackage
